//--- verilog/rv_arch_pkg.sv
package rv_arch_pkg;

    // RV64 base widths
    localparam int XLEN    = 64;
    localparam int NUM_GPR = 32;

    localparam int REG_ADDR_W = $clog2(NUM_GPR);  // 5 bits for x0..x31
    localparam int IMM_W      = 32;               // store offset as delivered by decode
    localparam int MASK_W     = XLEN / 8;         // one strobe per byte

    // sub-word widths used by the writeback extension
    localparam int WORD_W = 32;
    localparam int HALF_W = 16;

    // data word, also used for load/alu results
    typedef logic [XLEN-1:0] xlen_t;

    typedef logic [XLEN-1:0] pc_t;

    // register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // raw offset, sign extended at the adder
    typedef logic [IMM_W-1:0] imm_t;

    typedef logic [MASK_W-1:0] wmask_t;  // byte enables

endpackage

//--- verilog/wb_ctrl_pkg.sv
package wb_ctrl_pkg;

    import rv_arch_pkg::*;

    // extension applied to the value written back to rd
    typedef enum logic [1:0] {
        EXT_NONE = 2'd0,  // full 64 bits, jalr and friends
        EXT_SW   = 2'd1,  // lw, addw, divw
        EXT_ZW   = 2'd2,  // lwu
        EXT_SH   = 2'd3   // lh
    } ext_kind_e;

    // where the retiring value comes from
    typedef enum logic {
        SRC_EX  = 1'b0,
        SRC_MEM = 1'b1  // loads, mul/div and other late results
    } res_src_e;

    // per-instruction writeback control, 51 bits
    typedef struct packed {
        logic      rd_wen;
        reg_addr_t rd_addr;   // also the store base register
        logic      is_store;
        logic      store_en;  // store may fire in this cycle
        res_src_e  src;
        ext_kind_e ext;
        imm_t      imm;
        wmask_t    wmask;
    } wb_ctrl_t;

    // memory write request towards the data memory, 137 bits
    typedef struct packed {
        logic   wen;  // single-cycle pulse
        xlen_t  addr;
        xlen_t  data;
        wmask_t mask;
    } store_req_t;

endpackage

//--- verilog/wb_result_sel.sv
module wb_result_sel
    import rv_arch_pkg::*, wb_ctrl_pkg::*;
(
    input  res_src_e  ctrl_src,
    input  ext_kind_e ctrl_ext,
    input  xlen_t     ex_res,
    input  xlen_t     mem_res,
    input  logic      fwd_hazard,
    output xlen_t     raw_res,   // selected value, also the store data
    output xlen_t     wr_data    // extended value for rd
);

    logic use_mem;

    // a forwarding hazard means the memory value is stale here
    assign use_mem = (ctrl_src == SRC_MEM) && !fwd_hazard;
    assign raw_res = use_mem ? mem_res : ex_res;

    always_comb begin
        case (ctrl_ext)
            EXT_NONE: begin
                wr_data = raw_res;
            end
            EXT_SW: begin
                wr_data = {{(XLEN-WORD_W){raw_res[WORD_W-1]}}, raw_res[WORD_W-1:0]};
            end
            EXT_ZW: begin
                wr_data = {{(XLEN-WORD_W){1'b0}}, raw_res[WORD_W-1:0]};
            end
            EXT_SH: begin
                wr_data = {{(XLEN-HALF_W){raw_res[HALF_W-1]}}, raw_res[HALF_W-1:0]};
            end
            default: begin
                wr_data = raw_res;  // unreachable for a clean 2-bit code
            end
        endcase
    end

    // decode must never hand over an undefined extension code
    always_comb begin
        a_ext_known : assert final (ctrl_ext inside {EXT_NONE, EXT_SW, EXT_ZW, EXT_SH})
            else $error("wb_result_sel: illegal extension code %b", ctrl_ext);
    end

endmodule

//--- verilog/gpr_file.sv
module gpr_file
    import rv_arch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // write port from writeback
    input  logic      wen,
    input  reg_addr_t waddr,
    input  xlen_t     wdata,

    // store base read
    input  reg_addr_t base_addr,
    output xlen_t     base_data,

    // difftest hook
    input  reg_addr_t dbg_raddr,
    output xlen_t     dbg_rdata
);

    // x0 has no storage
    xlen_t regs [1:NUM_GPR-1];

    // zero for x0, stored value otherwise
    function automatic xlen_t read_reg(input reg_addr_t addr);
        xlen_t val;
        if (addr == '0) begin
            val = '0;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin  // writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    // both reads are combinational, no same-cycle bypass
    always_comb begin
        base_data = read_reg(base_addr);
    end

    always_comb begin
        dbg_rdata = read_reg(dbg_raddr);
    end

    // written data must be visible after the edge
    a_write_lands : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wen && (waddr != '0)) |=> (regs[$past(waddr)] == $past(wdata))
    ) else $error("gpr_file: write to x%0d did not land", $past(waddr));

endmodule

//--- verilog/wb_store_unit.sv
module wb_store_unit
    import rv_arch_pkg::*, wb_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  wb_ctrl_t   ctrl,
    input  xlen_t      base_data,   // rs1 value read through rd_addr
    input  xlen_t      store_data,  // unextended result
    output store_req_t store_req
);

    logic   issue;
    xlen_t  imm_sx;
    xlen_t  addr_d;

    logic   wen_q;
    xlen_t  addr_q;
    xlen_t  data_q;
    wmask_t mask_q;

    // x0 as base never issues a store
    assign issue = ctrl.is_store && ctrl.store_en && ctrl.rd_wen && (ctrl.rd_addr != '0);

    assign imm_sx = {{(XLEN-IMM_W){ctrl.imm[IMM_W-1]}}, ctrl.imm};
    assign addr_d = base_data + imm_sx;  // negative offsets wrap naturally

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_q <= 1'b0;
        end else begin
            wen_q <= issue;  // drops again unless the next cycle issues too
        end
    end

    // payload is sampled every cycle and read only with wen_q
    always_ff @(posedge clk) begin
        addr_q <= addr_d;
        data_q <= store_data;
        mask_q <= ctrl.wmask;
    end

    assign store_req = '{wen: wen_q, addr: addr_q, data: data_q, mask: mask_q};

    // back-to-back pulses need back-to-back store instructions
    a_single_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        (store_req.wen && $past(store_req.wen))
            |-> ($past(ctrl.is_store, 1) && $past(ctrl.is_store, 2))
    ) else $error("wb_store_unit: store write held without a second store");

endmodule

//--- verilog/wb_stage.sv
module wb_stage
    import rv_arch_pkg::*, wb_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  wb_ctrl_t   ctrl,
    input  xlen_t      ex_res,
    input  xlen_t      mem_res,
    input  logic       fwd_hazard,
    input  pc_t        wb_pc,
    input  logic       ebreak,
    input  reg_addr_t  dbg_raddr,

    output store_req_t store_req,
    output pc_t        delay_pc,
    output logic       halted,
    output xlen_t      dbg_rdata
);

    xlen_t raw_res;
    xlen_t wr_data;
    xlen_t base_data;
    logic  gpr_wen;

    // stores use rd_addr as base, so they must not write it
    assign gpr_wen = ctrl.rd_wen && !ctrl.is_store;

    wb_result_sel i_result_sel (
        .ctrl_src   (ctrl.src),
        .ctrl_ext   (ctrl.ext),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .fwd_hazard (fwd_hazard),
        .raw_res    (raw_res),
        .wr_data    (wr_data)
    );

    gpr_file i_gpr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wen       (gpr_wen),
        .waddr     (ctrl.rd_addr),
        .wdata     (wr_data),
        .base_addr (ctrl.rd_addr),
        .base_data (base_data),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

    wb_store_unit i_store_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .base_data  (base_data),
        .store_data (raw_res),
        .store_req  (store_req)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delay_pc <= '0;
        end else begin
            delay_pc <= wb_pc;  // retiring pc, one cycle late
        end
    end

    // sticky until reset, writes keep going
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (ebreak) begin
            halted <= 1'b1;
        end
    end

    a_halt_sticky : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$fell(halted)
    ) else $error("wb_stage: halted dropped without reset");

endmodule

//--- verification/tb_wb_stage.sv
module tb_wb_stage
    import rv_arch_pkg::*, wb_ctrl_pkg::*;
;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int APPLY_DELAY     = 2;   // after the rising edge
    localparam int CHECK_DELAY     = 16;  // lands just before the next edge
    localparam int NUM_LINES       = 28;  // lines in the trace file
    localparam int FIELDS          = 21;  // tokens per trace line
    localparam int WATCHDOG_MARGIN = 400;

    localparam logic [31:0] RAND_SEED = 32'h4bc0_f316;

    logic       clk;
    logic       rst_n;

    wb_ctrl_t   ctrl;
    xlen_t      ex_res;
    xlen_t      mem_res;
    logic       fwd_hazard;
    pc_t        wb_pc;
    logic       ebreak;
    reg_addr_t  dbg_raddr;

    store_req_t store_req;
    pc_t        delay_pc;
    logic       halted;
    xlen_t      dbg_rdata;

    // one token per entry, FIELDS entries per cycle
    logic [63:0] trace_mem [0:NUM_LINES*FIELDS-1];
    int          line_idx;

    wb_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .fwd_hazard (fwd_hazard),
        .wb_pc      (wb_pc),
        .ebreak     (ebreak),
        .dbg_raddr  (dbg_raddr),
        .store_req  (store_req),
        .delay_pc   (delay_pc),
        .halted     (halted),
        .dbg_rdata  (dbg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped at trace line %0d", line_idx);
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h (trace line %0d)", name, exp, act, line_idx);
            stop_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h (trace line %0d)", name, exp, act, line_idx);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h (trace line %0d)", name, exp, act, line_idx);
            stop_run();
        end
    endtask

    // payload is only meaningful while wen is high
    task automatic check_store(input store_req_t exp, input store_req_t act);
        check_flag("store_req.wen", exp.wen, act.wen);
        if (exp.wen) begin
            check_xlen("store_req.addr", exp.addr, act.addr);
            check_xlen("store_req.data", exp.data, act.data);
            if (act.mask !== exp.mask) begin
                $display("ERR store_req.mask: expected %h, actual %h (trace line %0d)",
                         exp.mask, act.mask, line_idx);
                stop_run();
            end
        end
    endtask

    function automatic xlen_t random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic apply_line(input int line);
        int   base;
        logic mem_chosen;
        base = line * FIELDS;
        ctrl.rd_wen   = trace_mem[base][0];
        ctrl.rd_addr  = trace_mem[base + 1][REG_ADDR_W-1:0];
        ctrl.is_store = trace_mem[base + 2][0];
        ctrl.store_en = trace_mem[base + 3][0];
        ctrl.src      = res_src_e'(trace_mem[base + 4][0]);
        ctrl.ext      = ext_kind_e'(trace_mem[base + 5][1:0]);
        ctrl.imm      = trace_mem[base + 6][IMM_W-1:0];
        ctrl.wmask    = trace_mem[base + 7][MASK_W-1:0];
        ex_res        = trace_mem[base + 8];
        mem_res       = trace_mem[base + 9];
        fwd_hazard    = trace_mem[base + 10][0];
        wb_pc         = trace_mem[base + 11];
        ebreak        = trace_mem[base + 12][0];
        dbg_raddr     = trace_mem[base + 13][REG_ADDR_W-1:0];

        // the source that must lose gets noise
        mem_chosen = (ctrl.src == SRC_MEM) && !fwd_hazard;
        if (mem_chosen) begin
            ex_res = random_word();
        end else begin
            mem_res = random_word();
        end
    endtask

    task automatic check_line(input int line);
        int         base;
        store_req_t exp_req;
        base = line * FIELDS;
        check_xlen("dbg_rdata", trace_mem[base + 14], dbg_rdata);
        exp_req.wen  = trace_mem[base + 15][0];
        exp_req.addr = trace_mem[base + 16];
        exp_req.data = trace_mem[base + 17];
        exp_req.mask = trace_mem[base + 18][MASK_W-1:0];
        check_store(exp_req, store_req);
        check_pc("delay_pc", trace_mem[base + 19], delay_pc);
        check_flag("halted", trace_mem[base + 20][0], halted);
    endtask

    initial begin
        rst_n      = 1'b0;
        ctrl       = '0;
        ex_res     = '0;
        mem_res    = '0;
        fwd_hazard = 1'b0;
        wb_pc      = '0;
        ebreak     = 1'b0;
        dbg_raddr  = '0;
        line_idx   = -1;  // still in reset

        void'($urandom(RAND_SEED));
        $readmemh("verification/wb_trace.txt", trace_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #APPLY_DELAY;
        rst_n = 1'b1;

        for (int line = 0; line < NUM_LINES; line++) begin
            @(posedge clk);
            #APPLY_DELAY;
            line_idx = line;
            apply_line(line);
            #CHECK_DELAY;
            check_line(line);
        end

        $display("Result: PASSED");
        $finish;
    end

    // generous bound, reset fits inside the margin
    initial begin
        #(NUM_LINES * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("watchdog expired: the trace did not finish, stuck at line %0d", line_idx);
        stop_run();
    end

endmodule

//--- build.f
verilog/rv_arch_pkg.sv
verilog/wb_ctrl_pkg.sv
verilog/wb_result_sel.sv
verilog/gpr_file.sv
verilog/wb_store_unit.sv
verilog/wb_stage.sv
verification/tb_wb_stage.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  # RTL, packages first
  - files:
      - verilog/rv_arch_pkg.sv
      - verilog/wb_ctrl_pkg.sv
      - verilog/wb_result_sel.sv
      - verilog/gpr_file.sv
      - verilog/wb_store_unit.sv
      - verilog/wb_stage.sv

  # testbench, top module tb_wb_stage
  - target: test
    files:
      - verification/tb_wb_stage.sv

//--- verification/wb_trace.txt
// in:  rd_wen rd_addr is_store store_en src ext imm wmask ex_res mem_res
//      fwd_hazard wb_pc ebreak dbg_raddr
// out: dbg_rdata st_wen st_addr st_data st_mask delay_pc halted
// the source column not selected by src/fwd_hazard is replaced by random data
0 00 0 0 0 0 0 00 0 0 0 1000 0 1f  0 0 0 0 00 0 0
1 01 0 0 0 0 0 00 123456789abcdef0 0 0 1004 0 01  0 0 0 0 00 1000 0
1 02 0 0 1 1 0 00 0 0123456780001234 0 1008 0 01  123456789abcdef0 0 0 0 00 1004 0
1 03 0 0 0 2 0 00 fedcba98f0000001 0 0 100c 0 02  ffffffff80001234 0 0 0 00 1008 0
1 04 0 0 1 3 0 00 0 1111222233338765 0 1010 0 03  f0000001 0 0 0 00 100c 0
1 05 0 0 0 3 0 00 aaaabbbbcccc1234 0 0 1014 0 04  ffffffffffff8765 0 0 0 00 1010 0
1 06 0 0 0 1 0 00 ffffffff7fffffff 0 0 1018 0 05  1234 0 0 0 00 1014 0
1 07 0 0 1 0 0 00 0badc0de0badc0de 0 1 101c 0 06  7fffffff 0 0 0 00 1018 0
1 00 0 0 0 0 0 00 deadbeefdeadbeef 0 0 1020 0 07  0badc0de0badc0de 0 0 0 00 101c 0
0 00 0 0 0 0 0 00 0 0 0 1024 0 00  0 0 0 0 00 1020 0
1 01 1 1 0 0 10 ff cafef00dcafef00d 0 0 1028 0 01  123456789abcdef0 0 0 0 00 1024 0
0 00 0 0 0 0 0 00 0 0 0 102c 0 01  123456789abcdef0 1 123456789abcdf00 cafef00dcafef00d ff 1028 0
1 02 1 1 1 1 fffffff0 0f 0 5555666677778888 0 1030 0 02  ffffffff80001234 0 0 0 00 102c 0
1 03 1 0 0 0 8 03 1 0 0 1034 0 02  ffffffff80001234 1 ffffffff80001224 5555666677778888 0f 1030 0
0 00 0 0 0 0 0 00 0 0 0 1038 0 03  f0000001 0 0 0 00 1034 0
1 04 1 1 1 0 7fffffff f0 0102030405060708 0 1 103c 0 04  ffffffffffff8765 0 0 0 00 1038 0
1 05 1 1 1 0 80000000 01 0 0a0b0c0d0e0f1011 0 1040 0 05  1234 1 7fff8764 0102030405060708 f0 103c 0
0 00 0 0 0 0 0 00 0 0 0 1044 0 04  ffffffffffff8765 1 ffffffff80001234 0a0b0c0d0e0f1011 01 1040 0
1 00 1 1 0 0 100 ff 77 0 0 1048 0 00  0 0 0 0 00 1044 0
0 00 0 0 0 0 0 00 0 0 0 104c 0 00  0 0 0 0 00 1048 0
1 08 0 0 0 0 0 00 42 0 0 1050 1 07  0badc0de0badc0de 0 0 0 00 104c 0
1 09 0 0 1 2 0 00 0 ffffffffffffffff 0 1054 0 08  42 0 0 0 00 1050 1
0 00 0 0 0 0 0 00 0 0 0 1058 0 09  ffffffff 0 0 0 00 1054 1
1 01 0 0 0 1 0 00 12345678 0 0 105c 0 1f  0 0 0 0 00 1058 1
0 00 0 0 0 0 0 00 0 0 0 1060 0 01  12345678 0 0 0 00 105c 1
0 00 0 0 0 0 0 00 0 0 0 2000 0 06  7fffffff 0 0 0 00 1060 1
0 00 0 0 0 0 0 00 0 0 0 0 1 00  0 0 0 0 00 2000 1
0 00 0 0 0 0 0 00 0 0 0 0 0 08  42 0 0 0 00 0 1
